//--- include/soc_defs.svh
// widths, address map, register offsets and constants of the SoC bus
`ifndef SOC_DEFS_SVH
`define SOC_DEFS_SVH

// bus widths
`define SOC_ADDR_W      16
`define SOC_DATA_W      32
`define SOC_N_CLUSTERS  4

// address map
`define L2_DEPTH        256
`define L2_BASE         16'h0000
`define L2_SIZE         16'h0400
`define PERIPH_BASE     16'h8000
`define PERIPH_SIZE     16'h0100

// peripheral register byte offsets
`define REG_FETCH_EN    8'h00
`define REG_EOC         8'h04
`define REG_SCRATCH     8'h08
`define REG_ID          8'h0C

`define SOC_ID_VALUE    32'h5c0c_0001

`endif

//--- source/soc_pkg.sv
// SoC bus types
// request, response and target select structs
`include "soc_defs.svh"

package soc_pkg;

  typedef logic [`SOC_ADDR_W-1:0]     addr_t;
  typedef logic [`SOC_DATA_W-1:0]     data_t;
  typedef logic [`SOC_N_CLUSTERS-1:0] cl_mask_t;

  // single-beat host request
  typedef struct packed {
    logic  we;
    addr_t addr;
    data_t wdata;
  } soc_req_t;

  // response back to the host
  typedef struct packed {
    logic  err;
    data_t rdata;
  } soc_rsp_t;

  // one-hot target select, err marks an unmapped address
  typedef struct packed {
    logic l2;
    logic periph;
    logic err;
  } tgt_sel_t;

endpackage

//--- source/soc_addr_decode.sv
// address decoder of the SoC bus
// one-hot select among L2, peripherals and decode error
`timescale 1ns/1ns
`include "soc_defs.svh"

module soc_addr_decode
  import soc_pkg::*;
(
  input  logic     req_valid_i,
  input  soc_req_t req_i,
  output tgt_sel_t sel_o
);

  addr_t l2_off;
  addr_t periph_off;
  logic  hit_l2;
  logic  hit_periph;

  // offsets from region bases, wrap-around keeps the range check to one compare
  assign l2_off     = req_i.addr - addr_t'(`L2_BASE);
  assign periph_off = req_i.addr - addr_t'(`PERIPH_BASE);

  assign hit_l2     = l2_off < addr_t'(`L2_SIZE);
  assign hit_periph = periph_off < addr_t'(`PERIPH_SIZE);

  always_comb begin
    sel_o = '0;
    if (req_valid_i) begin
      if (hit_l2) begin
        sel_o.l2 = 1'b1;
      end else if (hit_periph) begin
        sel_o.periph = 1'b1;
      end else begin
        // nothing mapped here
        sel_o.err = 1'b1;
      end
    end
  end

endmodule

//--- source/l2_mem.sv
// L2 word memory
// registered read data and write acknowledge
`timescale 1ns/1ns
`include "soc_defs.svh"

module l2_mem
  import soc_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     sel_i,
  input  soc_req_t req_i,
  output logic     valid_o,
  output data_t    rdata_o
);

  localparam int IDX_W = $clog2(`L2_DEPTH);

  data_t            mem [`L2_DEPTH];
  logic [IDX_W-1:0] word_idx;

  // byte address to word index, low two bits dropped
  assign word_idx = req_i.addr[IDX_W+1:2];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= sel_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (sel_i) begin
      if (req_i.we) begin
        mem[word_idx] <= req_i.wdata;
        // write ack carries no data
        rdata_o       <= '0;
      end else begin
        rdata_o <= mem[word_idx];
      end
    end
  end

endmodule

//--- source/soc_periph.sv
// peripheral register block
// cluster fetch-enable, eoc status, scratch and read-only ID
`timescale 1ns/1ns
`include "soc_defs.svh"

module soc_periph
  import soc_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     sel_i,
  input  soc_req_t req_i,
  input  cl_mask_t cl_eoc_i,
  output cl_mask_t cl_fetch_en_o,
  output logic     valid_o,
  output data_t    rdata_o
);

  localparam int OFF_W = $clog2(`PERIPH_SIZE);

  logic [OFF_W-1:0] reg_off;
  logic             wr_en;
  data_t            rd_data;
  cl_mask_t         fetch_en_q;
  data_t            scratch_q;

  // word-aligned offset inside the region
  assign reg_off = {req_i.addr[OFF_W-1:2], 2'b00};
  assign wr_en   = sel_i & req_i.we;

  assign cl_fetch_en_o = fetch_en_q;

  // read mux, unlisted offsets read zero
  always_comb begin
    rd_data = '0;
    if (!req_i.we) begin
      if (reg_off == OFF_W'(`REG_FETCH_EN)) begin
        rd_data = data_t'(fetch_en_q);
      end else if (reg_off == OFF_W'(`REG_EOC)) begin
        rd_data = data_t'(cl_eoc_i);
      end else if (reg_off == OFF_W'(`REG_SCRATCH)) begin
        rd_data = scratch_q;
      end else if (reg_off == OFF_W'(`REG_ID)) begin
        rd_data = data_t'(`SOC_ID_VALUE);
      end
    end
  end

  // writable registers, eoc and id ignore writes
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      fetch_en_q <= '0;
      scratch_q  <= '0;
    end else if (wr_en) begin
      if (reg_off == OFF_W'(`REG_FETCH_EN)) begin
        fetch_en_q <= req_i.wdata[`SOC_N_CLUSTERS-1:0];
      end
      if (reg_off == OFF_W'(`REG_SCRATCH)) begin
        scratch_q <= req_i.wdata;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= sel_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (sel_i) begin
      rdata_o <= rd_data;
    end
  end

endmodule

//--- source/soc_rsp_merge.sv
// response merger
// delays decode errors to line up with the target responses
`timescale 1ns/1ns

module soc_rsp_merge
  import soc_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     err_sel_i,
  input  logic     l2_valid_i,
  input  data_t    l2_rdata_i,
  input  logic     periph_valid_i,
  input  data_t    periph_rdata_i,
  output logic     rsp_valid_o,
  output soc_rsp_t rsp_o
);

  logic err_q;

  // one stage, same as the targets
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      err_q <= 1'b0;
    end else begin
      err_q <= err_sel_i;
    end
  end

  assign rsp_valid_o = err_q | l2_valid_i | periph_valid_i;
  assign rsp_o.err   = err_q;

  // at most one source is valid per cycle
  always_comb begin
    if (l2_valid_i) begin
      rsp_o.rdata = l2_rdata_i;
    end else if (periph_valid_i) begin
      rsp_o.rdata = periph_rdata_i;
    end else begin
      // error or idle, zero data
      rsp_o.rdata = '0;
    end
  end

endmodule

//--- source/soc_top.sv
// SoC bus top level
// decoder, L2 memory, peripheral registers and response merger
`timescale 1ns/1ns

module soc_top
  import soc_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     req_valid_i,
  input  soc_req_t req_i,
  output logic     rsp_valid_o,
  output soc_rsp_t rsp_o,
  input  cl_mask_t cl_eoc_i,
  output cl_mask_t cl_fetch_en_o
);

  tgt_sel_t sel;
  logic     l2_valid;
  data_t    l2_rdata;
  logic     periph_valid;
  data_t    periph_rdata;

  soc_addr_decode i_addr_decode (
    .req_valid_i (req_valid_i),
    .req_i       (req_i),
    .sel_o       (sel)
  );

  l2_mem i_l2_mem (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .sel_i   (sel.l2),
    .req_i   (req_i),
    .valid_o (l2_valid),
    .rdata_o (l2_rdata)
  );

  // cluster control lives in the peripheral block
  soc_periph i_periph (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .sel_i         (sel.periph),
    .req_i         (req_i),
    .cl_eoc_i      (cl_eoc_i),
    .cl_fetch_en_o (cl_fetch_en_o),
    .valid_o       (periph_valid),
    .rdata_o       (periph_rdata)
  );

  soc_rsp_merge i_rsp_merge (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .err_sel_i      (sel.err),
    .l2_valid_i     (l2_valid),
    .l2_rdata_i     (l2_rdata),
    .periph_valid_i (periph_valid),
    .periph_rdata_i (periph_rdata),
    .rsp_valid_o    (rsp_valid_o),
    .rsp_o          (rsp_o)
  );

endmodule

//--- sim/soc_top_checker.sv
// bus protocol assertions on the SoC top-level ports
// bound into soc_top
`timescale 1ns/1ns

module soc_top_checker
  import soc_pkg::*;
(
  input logic     clk_i,
  input logic     rst_n_i,
  input logic     req_valid_i,
  input logic     rsp_valid_o,
  input soc_rsp_t rsp_o,
  input cl_mask_t cl_fetch_en_o
);

  // every request answered one cycle later
  a_rsp_follows_req: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) req_valid_i |=> rsp_valid_o
  ) else $error("no response one cycle after a request");

  // no response without a request
  a_no_spurious_rsp: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) rsp_valid_o |-> $past(req_valid_i)
  ) else $error("response without a preceding request");

  a_err_zero_data: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) (rsp_valid_o && rsp_o.err) |-> rsp_o.rdata == '0
  ) else $error("error response carries nonzero data");

  // synchronous reset clears fetch enable
  a_fetch_en_reset: assert property (
    @(posedge clk_i) !rst_n_i |=> cl_fetch_en_o == '0
  ) else $error("cluster fetch enable not cleared by reset");

endmodule

bind soc_top soc_top_checker i_checker (
  .clk_i         (clk_i),
  .rst_n_i       (rst_n_i),
  .req_valid_i   (req_valid_i),
  .rsp_valid_o   (rsp_valid_o),
  .rsp_o         (rsp_o),
  .cl_fetch_en_o (cl_fetch_en_o)
);

//--- sim/soc_top_tb.sv
// testbench of the SoC bus
// data-file stimulus, in-order response checks, watchdog
`timescale 1ns/1ns
`include "soc_defs.svh"

module soc_top_tb
  import soc_pkg::*;
();

  localparam int    CLK_PERIOD    = 4;
  localparam int    DRIVE_DELAY   = 1;
  localparam int    RESET_CYCLES  = 8;
  localparam int    N_FIELDS      = 6;
  localparam int    MAX_TESTS     = 64;
  localparam addr_t FETCH_EN_ADDR = addr_t'(`PERIPH_BASE + `REG_FETCH_EN);

  // request waiting for its response
  typedef struct packed {
    logic [31:0] idx;
    logic [31:0] due;
  } pend_t;

  logic        clk_i;
  logic        rst_n_i;
  logic        req_valid_i;
  soc_req_t    req_i;
  logic        rsp_valid_o;
  soc_rsp_t    rsp_o;
  cl_mask_t    cl_eoc_i;
  cl_mask_t    cl_fetch_en_o;

  logic [31:0] tdata [MAX_TESTS*N_FIELDS];
  pend_t       pend_q[$];
  int          n_tests;
  int          n_errors;
  int          n_done;
  int          cyc = 0;
  bit          data_ready = 1'b0;
  cl_mask_t    exp_fetch_en;

  soc_top soc_top_i (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .req_valid_i   (req_valid_i),
    .req_i         (req_i),
    .rsp_valid_o   (rsp_valid_o),
    .rsp_o         (rsp_o),
    .cl_eoc_i      (cl_eoc_i),
    .cl_fetch_en_o (cl_fetch_en_o)
  );

  initial clk_i = 1'b0;
  always #(CLK_PERIOD/2) clk_i = ~clk_i;

  always @(posedge clk_i) cyc <= cyc + 1;

  function automatic logic [31:0] field(int t, int f);
    return tdata[t*N_FIELDS+f];
  endfunction

  task automatic load_tests();
    // op values above 3 mark the end of the data
    for (int i = 0; i < MAX_TESTS*N_FIELDS; i++) begin
      tdata[i] = ~32'(i);
    end
    $readmemh("sim/soc_testdata.txt", tdata);
    n_tests = 0;
    while (n_tests < MAX_TESTS && field(n_tests, 0) <= 32'd3) begin
      n_tests++;
    end
  endtask

  task automatic drive_test(int t);
    logic [31:0] op;
    pend_t       p;
    op          = field(t, 0);
    req_valid_i = 1'b1;
    req_i.we    = op[0];
    req_i.addr  = addr_t'(field(t, 1));
    req_i.wdata = field(t, 2);
    cl_eoc_i    = cl_mask_t'(field(t, 3));
    p.idx       = t;
    p.due       = cyc + 1;
    pend_q.push_back(p);
  endtask

  task automatic drive_idle();
    req_valid_i = 1'b0;
    req_i       = '0;
  endtask

  task automatic check_response(int t);
    logic [31:0] op;
    logic [31:0] exp_rdata;
    logic [31:0] err_word;
    addr_t       word_addr;
    int          errs_before;
    op          = field(t, 0);
    word_addr   = addr_t'(field(t, 1));
    exp_rdata   = field(t, 4);
    err_word    = field(t, 5);
    errs_before = n_errors;
    word_addr[1:0] = 2'b00;
    if (rsp_o.rdata !== exp_rdata) begin
      $display("Fail test %0d: rsp_o.rdata = %h, expected %h", t, rsp_o.rdata, exp_rdata);
      n_errors++;
    end
    if (rsp_o.err !== err_word[0]) begin
      $display("Fail test %0d: rsp_o.err = %h, expected %h", t, rsp_o.err, err_word[0]);
      n_errors++;
    end
    // fetch enable keeps only one bit per cluster
    if (op[0] && word_addr == FETCH_EN_ADDR) begin
      exp_fetch_en = cl_mask_t'(field(t, 2));
    end
    if (cl_fetch_en_o !== exp_fetch_en) begin
      $display("Fail test %0d: cl_fetch_en_o = %h, expected %h", t, cl_fetch_en_o, exp_fetch_en);
      n_errors++;
    end
    n_done++;
    if (n_errors == errs_before) begin
      $display("test %0d: ok", t);
    end else begin
      $display("test %0d: failed", t);
    end
  endtask

  // response monitor, sampled mid-cycle
  always @(negedge clk_i) begin
    pend_t p;
    if (rst_n_i) begin
      if (pend_q.size() != 0 && pend_q[0].due == cyc) begin
        p = pend_q.pop_front();
        if (!rsp_valid_o) begin
          $display("test %0d: no response one cycle after the request", p.idx);
          n_errors++;
        end else begin
          check_response(int'(p.idx));
        end
      end else if (rsp_valid_o) begin
        $display("response in cycle %0d without a matching request", cyc);
        n_errors++;
      end
    end
  end

  initial begin
    logic [31:0] op;
    rst_n_i      = 1'b0;
    req_valid_i  = 1'b0;
    req_i        = '0;
    cl_eoc_i     = '0;
    n_errors     = 0;
    n_done       = 0;
    exp_fetch_en = '0;
    load_tests();
    data_ready = 1'b1;
    if (n_tests == 0) begin
      $display("no tests found in the data file");
      n_errors++;
    end
    repeat (RESET_CYCLES) @(posedge clk_i);
    #DRIVE_DELAY;
    rst_n_i = 1'b1;
    if (cl_fetch_en_o !== '0) begin
      $display("Fail after reset: cl_fetch_en_o = %h, expected %h", cl_fetch_en_o, 4'h0);
      n_errors++;
    end
    for (int t = 0; t < n_tests; t++) begin
      @(posedge clk_i);
      #DRIVE_DELAY;
      drive_test(t);
      op = field(t, 0);
      // chained lines go out back to back
      if (!op[1]) begin
        @(posedge clk_i);
        #DRIVE_DELAY;
        drive_idle();
      end
    end
    @(posedge clk_i);
    #DRIVE_DELAY;
    drive_idle();
    while (pend_q.size() != 0) @(posedge clk_i);
    repeat (2) @(posedge clk_i);
    $display("tests: %0d, checked: %0d, errors: %0d", n_tests, n_done, n_errors);
    if (n_errors == 0 && n_done == n_tests) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // watchdog, ten cycles per test on top of reset
  initial begin
    wait (data_ready);
    repeat ((n_tests + 1) * 10 + RESET_CYCLES) @(posedge clk_i);
    $display("watchdog expired with %0d responses outstanding", pend_q.size());
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

//--- tb.f
+incdir+include
source/soc_pkg.sv
source/soc_addr_decode.sv
source/l2_mem.sv
source/soc_periph.sv
source/soc_rsp_merge.sv
source/soc_top.sv
sim/soc_top_checker.sv
sim/soc_top_tb.sv

//--- Makefile
# Verilator build and run of the SoC bus testbench

VERILATOR ?= verilator
TOP       ?= soc_top_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- sim/soc_testdata.txt
// op addr wdata eoc exp_rdata exp_err, all hex, one test per line
// op bit 0 marks a write, bit 1 issues the next line in the following cycle
0 8000 00000000 0 00000000 0
0 8008 00000000 0 00000000 0
0 800C 00000000 0 5c0c0001 0
1 0010 deadbeef 0 00000000 0
1 0014 12345678 0 00000000 0
0 0010 00000000 0 deadbeef 0
0 0014 00000000 0 12345678 0
1 8000 ffffffff 0 00000000 0
0 8000 00000000 0 0000000f 0
1 8000 00000005 0 00000000 0
0 8000 00000000 0 00000005 0
0 8004 00000000 a 0000000a 0
1 8008 cafef00d 0 00000000 0
0 8008 00000000 0 cafef00d 0
1 800C ffffffff 0 00000000 0
0 800C 00000000 0 5c0c0001 0
0 8010 00000000 0 00000000 0
1 4000 11111111 0 00000000 1
0 4000 00000000 0 00000000 1
0 0010 00000000 0 deadbeef 0
3 03FC a5a5a5a5 0 00000000 0
2 8008 00000000 0 cafef00d 0
2 03FC 00000000 0 a5a5a5a5 0
3 8004 ffffffff 5 00000000 0
2 8004 00000000 3 00000003 0
3 9000 00000000 0 00000000 1
2 0014 00000000 0 12345678 0
0 8000 00000000 6 00000005 0
